/* rtl/opcode_table.svh */
/*
 * opcode bytes of the supported 65816 subset, anything missing decodes as illegal
 */
`ifndef OPCODE_TABLE_SVH
`define OPCODE_TABLE_SVH
`default_nettype none

// ==========================================================
// single byte register and stack operations
// ==========================================================
`define NOP       8'hEA
`define CLC       8'h18
`define TAX       8'hAA
`define INX       8'hE8
`define DEX       8'hCA
`define PHA       8'h48

// ==========================================================
// control flow, fetching stops after each of these
// ==========================================================
`define BRK       8'h00
`define JMP       8'h4C
`define JML       8'h5C
`define JMP_IND   8'h6C
`define JMP_INDX  8'h7C
`define JSR       8'h20
`define JSL       8'h22
`define RTS       8'h60
`define RTL       8'h6B
`define RTI       8'h40
`define BRA       8'h80
`define BRL       8'h82
`define STP       8'hDB
`define WAI       8'hCB

// conditional branches fall through and keep fetching
`define BCC       8'h90
`define BCS       8'hB0
`define BNE       8'hD0
`define BEQ       8'hF0

// ==========================================================
// immediates and fixed operand modes
// ==========================================================
// accumulator width follows m16
`define LDA_IMM   8'hA9
`define ADC_IMM   8'h69
`define CMP_IMM   8'hC9
// index width follows xb16
`define LDX_IMM   8'hA2
`define LDY_IMM   8'hA0
`define CPX_IMM   8'hE0
// mode flag changes always carry a single byte
`define REP       8'hC2
`define SEP       8'hE2
`define LDA_ZP    8'hA5
`define STA_ZP    8'h85
`define LDA_ABS   8'hAD
`define STA_ABS   8'h8D
`define LDA_AL    8'hAF
`define STA_AL    8'h8F
`define LDA_DSP   8'hA3
`define STA_DSP   8'h83

`default_nettype wire
`endif

/* rtl/ifetch_pkg.sv */
/*
 * shared types of the 65816 prefetch unit, 24-bit byte addressed program space
 * instructions are 1 to 4 bytes long and operands are packed low byte first
 */
`default_nettype none

package ifetch_pkg;

	// ==========================================================
	// widths that carry a meaning
	// ==========================================================

	// program byte address covering the whole bank:offset space
	typedef logic [23:0] addr_t;

	// one datum of the 8-bit memory bus
	typedef logic [7:0] byte_t;

	// instruction length in bytes, only 1 to 4 are ever produced
	typedef logic [2:0] insn_len_t;

	// up to three operand bytes, the first byte after the opcode sits in bits 7:0
	typedef logic [23:0] operand_t;

	// ==========================================================
	// bundles passed between the stages
	// ==========================================================

	// a byte returned by the bus master together with the address it came from
	typedef struct packed {
		addr_t addr;
		byte_t data;
	} fetch_byte_t;

	// finished instruction as handed to the execute stage (61 bits)
	typedef struct packed {
		addr_t     pc;
		byte_t     opcode;
		operand_t  operand;
		insn_len_t len;
		logic      flow_stop;
		logic      illegal;
	} insn_pkt_t;

	// states of the instruction assembler
	typedef enum logic [2:0] {
		ASM_IDLE,
		ASM_OPCODE,
		ASM_OPERAND,
		ASM_PUSH,
		ASM_STOPPED
	} asm_state_t;

	// packet queue depth used when the top level is not told otherwise
	localparam int DEFAULT_QUEUE_DEPTH = 4;

endpackage

`default_nettype wire

/* rtl/opcode_len_dec.sv */
/*
 * purely combinational opcode table, the mode flags must be settled with the opcode
 * unknown opcodes come out as one byte, illegal and flow stopping
 */
`timescale 1ns/1ps
`include "opcode_table.svh"
`default_nettype none

module opcode_len_dec (
	input  wire ifetch_pkg::byte_t  opcode,
	input  wire                     m16,
	input  wire                     xb16,
	output ifetch_pkg::insn_len_t   len,
	output logic                    flow_stop,
	output logic                    illegal
);

	// ==========================================================
	// length and kind of every supported opcode
	// ==========================================================

	always_comb begin
		// most of the table only needs the length, so start from a plain one byte op
		len = 3'd1;
		flow_stop = 1'b0;
		illegal = 1'b0;
		case (opcode)
		// implied and stack ops carry no operand
		`NOP, `CLC, `TAX, `INX, `DEX, `PHA: len = 3'd1;

		// returns and halts end the stream with nothing after the opcode
		`RTS, `RTL, `RTI, `STP, `WAI: flow_stop = 1'b1;

		// brk carries its signature byte, bra its 8-bit displacement
		`BRK, `BRA: begin
			len = 3'd2;
			flow_stop = 1'b1;
		end

		// absolute jumps and calls plus the 16-bit long branch
		`JMP, `JMP_IND, `JMP_INDX, `JSR, `BRL: begin
			len = 3'd3;
			flow_stop = 1'b1;
		end

		// long jump and call take a full 24-bit target
		`JML, `JSL: begin
			len = 3'd4;
			flow_stop = 1'b1;
		end

		// conditional branches keep going down the fall-through path
		`BCC, `BCS, `BNE, `BEQ: len = 3'd2;

		// the immediate is as wide as the accumulator
		`LDA_IMM, `ADC_IMM, `CMP_IMM: len = m16 ? 3'd3 : 3'd2;

		// the immediate is as wide as the index registers
		`LDX_IMM, `LDY_IMM, `CPX_IMM: len = xb16 ? 3'd3 : 3'd2;

		// one operand byte whatever the mode
		`REP, `SEP, `LDA_ZP, `STA_ZP, `LDA_DSP, `STA_DSP: len = 3'd2;

		// 16-bit absolute address
		`LDA_ABS, `STA_ABS: len = 3'd3;

		// 24-bit long address
		`LDA_AL, `STA_AL: len = 3'd4;

		// not in the table, the core gets a one byte trap packet
		default: begin
			flow_stop = 1'b1;
			illegal = 1'b1;
		end
		endcase
	end

endmodule

`default_nettype wire

/* rtl/wb_fetch_master.sv */
/*
 * Wishbone classic read master, one byte per bus cycle and no error or retry handling
 * a cycle still open at a redirect runs to its ack and that byte is thrown away
 */
`timescale 1ns/1ps
`default_nettype none

module wb_fetch_master (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       redirect,
	input  wire ifetch_pkg::addr_t    redirect_pc,
	input  wire                       fetch_en,
	output logic                      cyc,
	output logic                      stb,
	output logic                      we,
	output ifetch_pkg::addr_t         adr,
	input  wire ifetch_pkg::byte_t    dat_i,
	input  wire                       ack,
	output logic                      byte_valid,
	output ifetch_pkg::fetch_byte_t   fetch_byte
);
	import ifetch_pkg::*;

	// address of the next byte to fetch
	addr_t fetch_addr;
	// set when a redirect lands on an open cycle
	logic discard;
	// high the cycle after an ack, keeps the bus idle for one cycle
	logic ack_q;
	logic bus_done;
	logic bus_start;

	assign bus_done = cyc & ack;
	// a new cycle needs a free bus, the idle gap, and the assembler asking for bytes
	assign bus_start = ~cyc & ~ack_q & fetch_en & ~redirect;
	assign stb = cyc;
	assign we = 1'b0;

	// ==========================================================
	// bus handshake
	// ==========================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			cyc <= 1'b0;
			discard <= 1'b0;
			ack_q <= 1'b0;
			byte_valid <= 1'b0;
		end else begin
			ack_q <= bus_done;
			// a byte from the old stream never reaches the assembler
			byte_valid <= bus_done & ~discard & ~redirect;
			if (bus_done) begin
				cyc <= 1'b0;
				discard <= 1'b0;
			end else if (cyc) begin
				if (redirect)
					discard <= 1'b1;
			end else if (bus_start) begin
				cyc <= 1'b1;
			end
		end
	end

	// ==========================================================
	// addresses and returned data
	// ==========================================================

	always_ff @(posedge clk) begin
		// adr stays put for the whole cycle even if fetch_addr is reloaded
		if (bus_start)
			adr <= fetch_addr;
		if (redirect)
			fetch_addr <= redirect_pc;
		else if (bus_done && !discard)
			fetch_addr <= fetch_addr + 24'd1;
		if (bus_done)
			fetch_byte <= '{addr: adr, data: dat_i};
	end

endmodule

`default_nettype wire

/* rtl/insn_assembler.sv */
/*
 * gathers one instruction at a time and accepts every byte offered to it
 * fetch_en drops on the last byte so nothing is fetched while a packet waits
 */
`timescale 1ns/1ps
`default_nettype none

module insn_assembler (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        redirect,
	input  wire                        m16,
	input  wire                        xb16,
	input  wire                        byte_valid,
	input  wire ifetch_pkg::fetch_byte_t fetch_byte,
	output logic                       fetch_en,
	output logic                       push_valid,
	output ifetch_pkg::insn_pkt_t      push_pkt,
	input  wire                        push_ready
);
	import ifetch_pkg::*;

	asm_state_t state;
	insn_pkt_t pkt;
	// bytes of the current instruction taken so far, the opcode counts as one
	insn_len_t byte_cnt;
	insn_len_t dec_len;
	logic dec_flow_stop;
	logic dec_illegal;
	logic opcode_in;
	logic operand_in;
	logic last_byte;
	logic [1:0] opnd_idx;

	// the table looks at every byte but only opcode bytes are kept
	opcode_len_dec i_len_dec (
		.opcode    (fetch_byte.data),
		.m16       (m16),
		.xb16      (xb16),
		.len       (dec_len),
		.flow_stop (dec_flow_stop),
		.illegal   (dec_illegal)
	);

	assign opcode_in = byte_valid && (state == ASM_OPCODE);
	assign operand_in = byte_valid && (state == ASM_OPERAND);
	assign last_byte = (opcode_in && dec_len == 3'd1) ||
		(operand_in && byte_cnt + 3'd1 == pkt.len);
	// the master samples this in the idle gap right after a byte, which is when it matters
	assign fetch_en = ((state == ASM_OPCODE) || (state == ASM_OPERAND)) && !last_byte;
	assign opnd_idx = byte_cnt[1:0] - 2'd1;
	assign push_valid = (state == ASM_PUSH);
	assign push_pkt = pkt;

	// ==========================================================
	// state machine
	// ==========================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ASM_STOPPED;
			byte_cnt <= '0;
		end else if (redirect) begin
			// a redirect drops any half gathered instruction
			state <= ASM_OPCODE;
			byte_cnt <= '0;
		end else begin
			case (state)
			ASM_OPCODE: if (opcode_in) begin
				byte_cnt <= 3'd1;
				state <= last_byte ? ASM_PUSH : ASM_OPERAND;
			end
			ASM_OPERAND: if (operand_in) begin
				byte_cnt <= byte_cnt + 3'd1;
				if (last_byte)
					state <= ASM_PUSH;
			end
			ASM_PUSH: if (push_ready) begin
				state <= pkt.flow_stop ? ASM_STOPPED : ASM_OPCODE;
			end
			// parked until the core redirects
			ASM_IDLE, ASM_STOPPED: state <= state;
			default: state <= ASM_STOPPED;
			endcase
		end
	end

	// ==========================================================
	// packet fields
	// ==========================================================

	always_ff @(posedge clk) begin
		if (opcode_in) begin
			pkt.pc <= fetch_byte.addr;
			pkt.opcode <= fetch_byte.data;
			// operand bytes that never arrive stay zero
			pkt.operand <= '0;
			pkt.len <= dec_len;
			pkt.flow_stop <= dec_flow_stop;
			pkt.illegal <= dec_illegal;
		end else if (operand_in) begin
			pkt.operand[8*opnd_idx +: 8] <= fetch_byte.data;
		end
	end

endmodule

`default_nettype wire

/* rtl/insn_out_queue.sv */
/*
 * packet FIFO for any depth of 2 or more, flush drops everything held
 * push_ready looks straight through to out_ready so a full queue still streams
 */
`timescale 1ns/1ps
`default_nettype none

module insn_out_queue #(
	parameter int QUEUE_DEPTH = ifetch_pkg::DEFAULT_QUEUE_DEPTH
) (
	input  wire                         clk,
	input  wire                         rst,
	input  wire                         flush,
	input  wire                         push_valid,
	input  wire ifetch_pkg::insn_pkt_t  push_pkt,
	output logic                        push_ready,
	output logic                        out_valid,
	output ifetch_pkg::insn_pkt_t       out_pkt,
	input  wire                         out_ready
);
	import ifetch_pkg::*;

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	typedef logic [PTR_W-1:0] ptr_t;
	typedef logic [CNT_W-1:0] cnt_t;

	insn_pkt_t slots [QUEUE_DEPTH];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	cnt_t count;
	logic full;
	logic do_push;
	logic do_pop;

	// pointers wrap by hand since the depth need not be a power of two
	function automatic ptr_t ptr_next(input ptr_t p);
		return (p == ptr_t'(QUEUE_DEPTH - 1)) ? '0 : p + ptr_t'(1);
	endfunction

	assign full = (count == cnt_t'(QUEUE_DEPTH));
	assign out_valid = (count != '0);
	assign out_pkt = slots[rd_ptr];
	// when full a pop this cycle frees the slot the push needs
	assign push_ready = !full || out_ready;
	assign do_pop = out_valid && out_ready;
	assign do_push = push_valid && push_ready && !flush;

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_next(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_next(rd_ptr);
			case ({do_push, do_pop})
			2'b10: count <= count + cnt_t'(1);
			2'b01: count <= count - cnt_t'(1);
			default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			slots[wr_ptr] <= push_pkt;
	end

endmodule

`default_nettype wire

/* rtl/ifetch_top.sv */
/*
 * prefetch unit for an 8-bit memory 65816 core, idle after reset until the first redirect
 * m16 and xb16 must be valid whenever an opcode byte comes back from memory
 */
`timescale 1ns/1ps
`default_nettype none

module ifetch_top #(
	parameter int QUEUE_DEPTH = ifetch_pkg::DEFAULT_QUEUE_DEPTH
) (
	input  wire                        clk,
	input  wire                        rst,
	// Wishbone classic memory port, reads only
	output logic                       cyc,
	output logic                       stb,
	output logic                       we,
	output ifetch_pkg::addr_t          adr,
	input  wire ifetch_pkg::byte_t     dat_i,
	input  wire                        ack,
	// control from the core
	input  wire                        redirect,
	input  wire ifetch_pkg::addr_t     redirect_pc,
	input  wire                        m16,
	input  wire                        xb16,
	// packets to the execute stage
	output logic                       out_valid,
	output ifetch_pkg::insn_pkt_t      out_pkt,
	input  wire                        out_ready
);
	import ifetch_pkg::*;

	logic byte_valid;
	fetch_byte_t fetch_byte;
	logic fetch_en;
	logic push_valid;
	insn_pkt_t push_pkt;
	logic push_ready;

	// bytes come in from memory
	wb_fetch_master i_master (
		.clk         (clk),
		.rst         (rst),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.fetch_en    (fetch_en),
		.cyc         (cyc),
		.stb         (stb),
		.we          (we),
		.adr         (adr),
		.dat_i       (dat_i),
		.ack         (ack),
		.byte_valid  (byte_valid),
		.fetch_byte  (fetch_byte)
	);

	// bytes become instructions
	insn_assembler i_assembler (
		.clk        (clk),
		.rst        (rst),
		.redirect   (redirect),
		.m16        (m16),
		.xb16       (xb16),
		.byte_valid (byte_valid),
		.fetch_byte (fetch_byte),
		.fetch_en   (fetch_en),
		.push_valid (push_valid),
		.push_pkt   (push_pkt),
		.push_ready (push_ready)
	);

	// redirect also clears whatever the core has not taken yet
	insn_out_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) i_queue (
		.clk        (clk),
		.rst        (rst),
		.flush      (redirect),
		.push_valid (push_valid),
		.push_pkt   (push_pkt),
		.push_ready (push_ready),
		.out_valid  (out_valid),
		.out_pkt    (out_pkt),
		.out_ready  (out_ready)
	);

endmodule

`default_nettype wire

/* verification/wb_prog_mem.sv */
/*
 * Wishbone classic read-only program memory, 0 to 3 wait cycles drawn from SEED
 * addresses past MEM_SIZE read a fill pattern, writes are never acknowledged
 */
`timescale 1ns/1ps
`default_nettype none

module wb_prog_mem #(
	parameter int          MEM_SIZE = 131072,
	parameter logic [31:0] SEED     = 32'h92c0
) (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    cyc,
	input  wire                    stb,
	input  wire                    we,
	input  wire ifetch_pkg::addr_t adr,
	output ifetch_pkg::byte_t      dat_o,
	output logic                   ack
);
	import ifetch_pkg::*;

	byte_t mem [MEM_SIZE];
	integer seed;
	// wait cycles left before the ack of the open cycle
	int wait_cnt;
	logic busy;

	// every bank and offset bit takes part, so an aliased read shows up as a wrong byte
	function automatic byte_t fill_byte(input addr_t a);
		return a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'hA5;
	endfunction

	function automatic byte_t read_byte(input addr_t a);
		if (a < MEM_SIZE)
			return mem[a];
		return fill_byte(a);
	endfunction

	initial begin
		seed = SEED;
		ack = 1'b0;
		dat_o = '0;
		for (int i = 0; i < MEM_SIZE; i++)
			mem[i] = fill_byte(addr_t'(i));
	end

	// ==========================================================
	// slave handshake
	// ==========================================================

	// the ack is registered, so even a zero wait draw answers one cycle after stb
	always @(posedge clk) begin : respond
		int delay;
		if (rst) begin
			ack <= 1'b0;
			busy <= 1'b0;
			wait_cnt <= 0;
			dat_o <= '0;
		end else begin
			ack <= 1'b0;
			// the guard on ack keeps a second ack off the cycle the master lets go
			if (cyc && stb && !we && !ack) begin
				if (!busy) begin
					delay = $random(seed) & 3;
					if (delay == 0) begin
						ack <= 1'b1;
						dat_o <= read_byte(adr);
					end else begin
						busy <= 1'b1;
						wait_cnt <= delay;
					end
				end else if (wait_cnt == 1) begin
					ack <= 1'b1;
					busy <= 1'b0;
					dat_o <= read_byte(adr);
				end else begin
					wait_cnt <= wait_cnt - 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* verification/tb_ifetch_top.sv */
/*
 * replays verification/ifetch_trace.txt, so the simulator must run from the project root
 * every packet is compared field by field and the first error ends the run
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ifetch_top;
	import ifetch_pkg::*;

	localparam logic [31:0] RAND_SEED = 32'h92c0;
	localparam int MEM_SIZE = 131072;
	localparam int HOLD_CYCLES = 20;
	localparam int CYCLES_PER_LINE = 200;

	// a redirect from the trace, exp_before counts the packets expected ahead of it
	typedef struct packed {
		addr_t       pc;
		logic        m16;
		logic        xb16;
		logic [31:0] exp_before;
	} redirect_rec_t;

	logic clk;
	logic rst;
	logic cyc;
	logic stb;
	logic we;
	addr_t adr;
	byte_t dat_i;
	logic ack;
	logic redirect;
	addr_t redirect_pc;
	logic m16;
	logic xb16;
	logic out_valid;
	insn_pkt_t out_pkt;
	logic out_ready;

	fetch_byte_t preload_q[$];
	redirect_rec_t redirect_q[$];
	insn_pkt_t expect_q[$];
	int trace_lines;
	logic trace_loaded = 1'b0;
	int rcv_count;
	integer seed;
	// pc the next packet must carry, redirect_pc or previous pc plus len
	addr_t next_pc;
	// set by a flow-stop packet and cleared by the next redirect
	logic stream_stopped;

	ifetch_top #(
		.QUEUE_DEPTH (DEFAULT_QUEUE_DEPTH)
	) i_dut (
		.clk         (clk),
		.rst         (rst),
		.cyc         (cyc),
		.stb         (stb),
		.we          (we),
		.adr         (adr),
		.dat_i       (dat_i),
		.ack         (ack),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.m16         (m16),
		.xb16        (xb16),
		.out_valid   (out_valid),
		.out_pkt     (out_pkt),
		.out_ready   (out_ready)
	);

	wb_prog_mem #(
		.MEM_SIZE (MEM_SIZE),
		.SEED     (RAND_SEED)
	) i_mem (
		.clk   (clk),
		.rst   (rst),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_o (dat_i),
		.ack   (ack)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ==========================================================
	// failure reporting
	// ==========================================================

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
		end
	endtask

	// ==========================================================
	// trace reading
	// ==========================================================

	task automatic load_trace();
		int fd;
		int n;
		logic [8*160-1:0] line;
		logic [8*8-1:0] kind;
		logic [31:0] f1, f2, f3, f4, f5, f6;
		fetch_byte_t pre;
		redirect_rec_t rec;
		insn_pkt_t pkt;
		fd = $fopen("verification/ifetch_trace.txt", "r");
		if (fd == 0)
			abort_run("cannot open the trace file verification/ifetch_trace.txt");
		while (!$feof(fd)) begin
			line = '0;
			kind = '0;
			n = $fgets(line, fd);
			if (n > 0)
				n = $sscanf(line, "%s", kind);
			// blank lines and lines starting with # carry no record
			if (n > 0 && kind != "#") begin
				trace_lines++;
				case (kind)
				"M": begin
					n = $sscanf(line, "%s %h %h", kind, f1, f2);
					if (n != 3)
						abort_run($sformatf("trace record %0d is a broken preload", trace_lines));
					pre.addr = f1[23:0];
					pre.data = f2[7:0];
					preload_q.push_back(pre);
				end
				"R": begin
					n = $sscanf(line, "%s %h %h %h", kind, f1, f2, f3);
					if (n != 4)
						abort_run($sformatf("trace record %0d is a broken redirect", trace_lines));
					rec.pc = f1[23:0];
					rec.m16 = f2[0];
					rec.xb16 = f3[0];
					rec.exp_before = expect_q.size();
					redirect_q.push_back(rec);
				end
				"P": begin
					n = $sscanf(line, "%s %h %h %h %h %h %h", kind, f1, f2, f3, f4, f5, f6);
					if (n != 7)
						abort_run($sformatf("trace record %0d is a broken packet", trace_lines));
					pkt.pc = f1[23:0];
					pkt.opcode = f2[7:0];
					pkt.operand = f3[23:0];
					pkt.len = f4[2:0];
					pkt.flow_stop = f5[0];
					pkt.illegal = f6[0];
					expect_q.push_back(pkt);
				end
				default: abort_run($sformatf("trace record %0d has an unknown kind", trace_lines));
				endcase
			end
		end
		$fclose(fd);
	endtask

	task automatic preload_memory();
		foreach (preload_q[i]) begin
			if (preload_q[i].addr >= MEM_SIZE)
				abort_run($sformatf("preload address %h is outside the memory", preload_q[i].addr));
			i_mem.mem[preload_q[i].addr] = preload_q[i].data;
		end
	endtask

	// ==========================================================
	// packet checking
	// ==========================================================

	task automatic check_packet(input insn_pkt_t act);
		insn_pkt_t exp;
		string tag;
		if (rcv_count >= expect_q.size()) begin
			abort_run($sformatf("packet at pc %h arrived with no expected record left", act.pc));
		end else begin
			exp = expect_q[rcv_count];
			tag = $sformatf("packet %0d", rcv_count);
			check_value({tag, " pc"}, exp.pc, act.pc);
			check_value({tag, " opcode"}, exp.opcode, act.opcode);
			check_value({tag, " operand"}, exp.operand, act.operand);
			check_value({tag, " len"}, exp.len, act.len);
			check_value({tag, " flow_stop"}, exp.flow_stop, act.flow_stop);
			check_value({tag, " illegal"}, exp.illegal, act.illegal);
			// no gap and no repeat, each pc follows the expected one before it by its length
			check_value({tag, " pc sequence"}, next_pc, act.pc);
			next_pc = exp.pc + addr_t'(exp.len);
			if (act.flow_stop)
				stream_stopped = 1'b1;
			rcv_count++;
		end
	endtask

	// values are sampled on the edge, one ns before the inputs move
	always @(posedge clk) begin
		if (!rst) begin
			// the memory port only ever reads and stb moves with cyc
			check_value("wishbone stb", cyc, stb);
			check_value("wishbone we", 1'b0, we);
			if (out_valid && stream_stopped)
				abort_run("out_valid went high while fetching should be stopped");
			if (out_valid && out_ready)
				check_packet(out_pkt);
		end
	end

	// ==========================================================
	// stimulus
	// ==========================================================

	// random out_ready until limit packets are in, then out_ready stays low
	task automatic stream_until(input int limit);
		while (rcv_count < limit) begin
			@(posedge clk);
			#1;
			if (rcv_count < limit)
				out_ready = ($random(seed) & 32'sd1) != 0;
			else
				out_ready = 1'b0;
		end
	endtask

	initial begin
		rst = 1'b1;
		redirect = 1'b0;
		redirect_pc = '0;
		m16 = 1'b0;
		xb16 = 1'b0;
		out_ready = 1'b0;
		seed = RAND_SEED;
		rcv_count = 0;
		next_pc = '0;
		stream_stopped = 1'b1;
		load_trace();
		trace_loaded = 1'b1;
		@(posedge clk);
		#1;
		preload_memory();
		@(posedge clk);
		#1;
		rst = 1'b0;
		foreach (redirect_q[r]) begin
			stream_until(redirect_q[r].exp_before);
			// the queue and the prefetch get time to fill before the flush
			repeat (HOLD_CYCLES) @(posedge clk);
			#1;
			redirect = 1'b1;
			redirect_pc = redirect_q[r].pc;
			m16 = redirect_q[r].m16;
			xb16 = redirect_q[r].xb16;
			next_pc = redirect_q[r].pc;
			stream_stopped = 1'b0;
			@(posedge clk);
			#1;
			redirect = 1'b0;
		end
		stream_until(expect_q.size());
		// a stopped stream must stay quiet after its last packet
		repeat (HOLD_CYCLES) @(posedge clk);
		$display("TEST PASS");
		$finish;
	end

	// the budget grows with the trace, each record gets a fixed number of cycles
	initial begin
		wait (trace_loaded);
		repeat (CYCLES_PER_LINE * trace_lines) @(posedge clk);
		abort_run($sformatf("timeout, trace not finished after %0d cycles",
			CYCLES_PER_LINE * trace_lines));
	end

endmodule

`default_nettype wire

/* verification/ifetch_trace.txt */
# M addr byte | R pc m16 xb16 | P pc opcode operand len flow_stop illegal
# all values hex, operand bytes low byte first as the first byte after the opcode
# fixed length groups ending in jmp
M 000100 EA
M 000101 A5
M 000102 12
M 000103 AD
M 000104 34
M 000105 12
M 000106 AF
M 000107 56
M 000108 34
M 000109 12
M 00010A A3
M 00010B 05
M 00010C 4C
M 00010D 00
M 00010E 02
# immediates read under both mode settings, ending in rts
M 000200 A9
M 000201 EA
M 000202 EA
M 000203 A2
M 000204 EA
M 000205 EA
M 000206 60
# stream that is cut by a redirect while packets wait
M 000300 EA
M 000301 AA
M 000302 CA
M 000303 48
# bank 01, unknown opcode after inx
M 010000 E8
M 010001 02
R 000100 0 0
P 000100 EA 000000 1 0 0
P 000101 A5 000012 2 0 0
P 000103 AD 001234 3 0 0
P 000106 AF 123456 4 0 0
P 00010A A3 000005 2 0 0
P 00010C 4C 000200 3 1 0
R 000200 1 1
P 000200 A9 00EAEA 3 0 0
P 000203 A2 00EAEA 3 0 0
P 000206 60 000000 1 1 0
R 000200 0 0
P 000200 A9 0000EA 2 0 0
P 000202 EA 000000 1 0 0
P 000203 A2 0000EA 2 0 0
P 000205 EA 000000 1 0 0
P 000206 60 000000 1 1 0
R 000300 0 0
P 000300 EA 000000 1 0 0
P 000301 AA 000000 1 0 0
R 010000 0 0
P 010000 E8 000000 1 0 0
P 010001 02 000000 1 1 1

/* src.f */
+incdir+rtl
rtl/ifetch_pkg.sv
rtl/opcode_len_dec.sv
rtl/wb_fetch_master.sv
rtl/insn_assembler.sv
rtl/insn_out_queue.sv
rtl/ifetch_top.sv
verification/wb_prog_mem.sv
verification/tb_ifetch_top.sv

/* Bender.yml */
package:
  name: ifetch

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ifetch_pkg.sv
      - rtl/opcode_len_dec.sv
      - rtl/wb_fetch_master.sv
      - rtl/insn_assembler.sv
      - rtl/insn_out_queue.sv
      - rtl/ifetch_top.sv
  - target: test
    files:
      - verification/wb_prog_mem.sv
      - verification/tb_ifetch_top.sv
